// File: verilog/flp_pkg.sv
// Single precision float format
// Format constants, the float word with its two views, unpacked operand

package flp_pkg;

	localparam int EWIDTH = 8;				// Exponent width
	localparam int SWIDTH = 23;				// Stored significand width
	localparam int RSWIDTH = 23;				// Guard bits for align and round
	localparam int FWIDTH = 1 + EWIDTH + SWIDTH;		// Float word width
	localparam logic [EWIDTH-1:0] BIAS = EWIDTH'((1 << (EWIDTH - 1)) - 1);
	localparam logic [FWIDTH-1:0] QNAN = 32'h7FC0_0000;	// Canonical quiet NaN

	// One float word, raw bits or sign/exponent/fraction
	typedef union packed {
		logic [FWIDTH-1:0]		bits;
		struct packed {
			logic			sign;
			logic [EWIDTH-1:0]	exp;
			logic [SWIDTH-1:0]	frac;
		} f;
	} flp_word_t;

	// Operand after unpacking
	typedef struct packed {
		logic			sign;
		logic [EWIDTH-1:0]	exp;	// Biased, zero for zero operands
		logic [SWIDTH:0]	sig;	// With hidden bit
		logic			zero;	// Also set for denormals
		logic			nan;
		logic			inf;
	} flp_unpacked_t;

endpackage

// File: verilog/vmac_pkg.sv
// Vector MAC unit types
// Lane count, request, lane operand, lane result and summary flags

package vmac_pkg;

	localparam int N_LANES = 4;	// Vector length

	typedef struct packed {
		flp_pkg::flp_word_t			b;	// Scalar multiplier
		flp_pkg::flp_word_t [N_LANES-1:0]	a;	// Accumulators
		flp_pkg::flp_word_t [N_LANES-1:0]	c;	// Multiplicands
		logic					valid;	// One-cycle strobe
	} vmac_req_t;

	typedef struct packed {
		flp_pkg::flp_unpacked_t	a;
		flp_pkg::flp_unpacked_t	b;	// Same in every lane
		flp_pkg::flp_unpacked_t	c;
		logic			valid;
	} lane_in_t;

	// Lane result before packing
	typedef struct packed {
		logic				sign;
		logic [flp_pkg::EWIDTH-1:0]	exp;
		logic [flp_pkg::SWIDTH:0]	sig;	// Rounded, hidden bit on top
		logic				zero;
		logic				nan;
		logic				inf;
		logic				valid;
	} lane_res_t;

	typedef struct packed {
		logic	any_nan;
		logic	any_inf;
		logic	all_zero;
		logic	valid;
	} vmac_status_t;

endpackage

// File: verilog/vmac_dispatch.sv
`timescale 1ns/1ps

// Vector MAC dispatch
// Registers the request and unpacks the scalar and vector operands
// into one operand set per lane

module vmac_dispatch (
	input  logic						clk,
	input  logic						nrst,
	input  vmac_pkg::vmac_req_t				i_req,	// Request and strobe
	output vmac_pkg::lane_in_t [vmac_pkg::N_LANES-1:0]	o_lane	// Unpacked per lane
);

	vmac_pkg::vmac_req_t	req_q;	// Registered request
	flp_pkg::flp_unpacked_t	b_u;	// Scalar b, one copy for all lanes

	// Split a float word, denormals read as zero
	function automatic flp_pkg::flp_unpacked_t unpack(input flp_pkg::flp_word_t w);
		flp_pkg::flp_unpacked_t	u;
		logic			mag_zero;
		logic			exp_max;
		mag_zero = ~|w.bits[flp_pkg::FWIDTH-2:0];	// +0 or -0
		exp_max = &w.f.exp;				// Inf or NaN
		u.sign = w.f.sign;
		u.zero = mag_zero | (w.f.exp == '0);		// Denormal as zero
		u.nan = exp_max & (w.f.frac != '0);
		u.inf = exp_max & (w.f.frac == '0);
		u.exp = u.zero ? '0 : w.f.exp;
		u.sig = u.zero ? '0 : {1'b1, w.f.frac};	// Hidden bit set
		return u;
	endfunction

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			req_q.valid <= 1'b0;
		else
		begin
			req_q.valid <= i_req.valid;
			if (i_req.valid)
			begin
				req_q.b <= i_req.b;	// Operands sampled on strobe only
				req_q.a <= i_req.a;
				req_q.c <= i_req.c;
			end
		end
	end

	assign b_u = unpack(req_q.b);

	always_comb
	begin
		for (int k = 0; k < vmac_pkg::N_LANES; k++)
		begin
			o_lane[k].a = unpack(req_q.a[k]);
			o_lane[k].b = b_u;			// Broadcast scalar
			o_lane[k].c = unpack(req_q.c[k]);
			o_lane[k].valid = req_q.valid;
		end
	end

endmodule

// File: verilog/flp_mac_lane.sv
`timescale 1ns/1ps

// Single precision multiply-accumulate lane, a + b*c
// Four stages: exact product, align and add, normalize, round.
// Guard bits below the window are truncated, rounding is nearest even

module flp_mac_lane (
	input  logic			clk,
	input  logic			nrst,
	input  vmac_pkg::lane_in_t	i_op,	// Unpacked a, b, c
	output vmac_pkg::lane_res_t	o_res	// Rounded result and flags
);

	localparam int EW = flp_pkg::EWIDTH;
	localparam int SW = flp_pkg::SWIDTH;
	localparam int XW = EW + 3;				// Signed exponent width
	localparam int PW = 2 * (SW + 1);			// Exact product, 48
	localparam int SUMW = PW + flp_pkg::RSWIDTH + 1;	// Sum window, 72
	localparam int UNIT = 2 * SW + flp_pkg::RSWIDTH;	// Unit bit in window
	localparam int LZW = $clog2(SUMW);
	localparam logic signed [XW-1:0] EMAX = (1 << EW) - 1;	// All-ones exponent

	typedef struct packed {
		logic			valid;
		flp_pkg::flp_unpacked_t	a;	// Accumulator rides along
		logic			p_sign;
		logic signed [XW-1:0]	p_exp;	// Biased, unit at bit PW-2
		logic [PW-1:0]		p_sig;
		logic			p_zero;
		logic			p_nan;
		logic			p_inf;
	} prod_t;

	// Used for both the raw sum and the normalized sum
	typedef struct packed {
		logic			valid;
		logic			sign;
		logic signed [XW-1:0]	exp;	// Exponent of the unit bit
		logic [SUMW-1:0]	mag;
		logic			zero;	// Cancelled or both zero
		logic			nan;
		logic			inf;
		logic			inf_sign;
	} sum_t;

	prod_t			s1_d;
	prod_t			s1;
	sum_t			s2_d;
	sum_t			s2;
	sum_t			s3_d;
	sum_t			s3;
	logic signed [XW-1:0]	a_exp;
	logic [SUMW-1:0]	a_win;	// a placed in the window
	logic [SUMW-1:0]	p_win;	// Product placed in the window
	logic			a_big;	// a has the larger exponent
	logic [XW-1:0]		shamt;
	logic [SUMW-1:0]	big_win;
	logic [SUMW-1:0]	sml_win;
	logic			sml_sign;
	logic [LZW-1:0]		lead;	// Leading one position
	logic			up;	// Round increment
	logic [SW+1:0]		rnd;	// Rounded significand with carry
	logic signed [XW-1:0]	r_exp;
	logic			ovf;
	logic			unf;
	vmac_pkg::lane_res_t	res_d;

	function automatic logic [LZW-1:0] lead_one(input logic [SUMW-1:0] v);
		logic [LZW-1:0]	pos;
		pos = '0;
		for (int i = 0; i < SUMW; i++)
		begin
			if (v[i])
				pos = LZW'(i);	// Highest set bit wins
		end
		return pos;
	endfunction

	// Product exponent, flags and exact significand product
	always_comb
	begin
		s1_d.valid = i_op.valid;
		s1_d.a = i_op.a;
		s1_d.p_sign = i_op.b.sign ^ i_op.c.sign;
		s1_d.p_exp = $signed({{(XW-EW){1'b0}}, i_op.b.exp})
			+ $signed({{(XW-EW){1'b0}}, i_op.c.exp})
			- $signed({{(XW-EW){1'b0}}, flp_pkg::BIAS});
		s1_d.p_sig = i_op.b.sig * i_op.c.sig;		// 24x24, exact
		s1_d.p_zero = i_op.b.zero | i_op.c.zero;
		s1_d.p_nan = i_op.b.nan | i_op.c.nan | (i_op.b.zero & i_op.c.inf)
			| (i_op.b.inf & i_op.c.zero);		// Zero times inf
		s1_d.p_inf = i_op.b.inf | i_op.c.inf;
	end

	// Align to the larger exponent and add with signs
	assign a_exp = $signed({{(XW-EW){1'b0}}, s1.a.exp});
	assign a_win = {{(SUMW-1-UNIT){1'b0}}, s1.a.sig, {(UNIT-SW){1'b0}}};
	assign p_win = {1'b0, s1.p_sig, {flp_pkg::RSWIDTH{1'b0}}};

	always_comb
	begin
		a_big = s1.a.zero ? 1'b0 : (s1.p_zero | (a_exp >= s1.p_exp));
		big_win = a_big ? a_win : p_win;
		shamt = a_big ? a_exp - s1.p_exp : s1.p_exp - a_exp;
		sml_win = (a_big ? p_win : a_win) >> shamt;	// Low bits dropped
		sml_sign = a_big ? s1.p_sign : s1.a.sign;
		s2_d.valid = s1.valid;
		s2_d.exp = a_big ? a_exp : s1.p_exp;
		s2_d.sign = a_big ? s1.a.sign : s1.p_sign;
		if (sml_sign == s2_d.sign)
			s2_d.mag = big_win + sml_win;
		else if (big_win >= sml_win)
			s2_d.mag = big_win - sml_win;
		else
		begin
			s2_d.mag = sml_win - big_win;	// Smaller exponent, larger value
			s2_d.sign = sml_sign;
		end
		s2_d.zero = (s2_d.mag == '0);
		s2_d.nan = s1.a.nan | s1.p_nan
			| (s1.a.inf & s1.p_inf & (s1.a.sign ^ s1.p_sign));	// inf - inf
		s2_d.inf = s1.a.inf | s1.p_inf;
		s2_d.inf_sign = s1.a.inf ? s1.a.sign : s1.p_sign;
	end

	// Leading one to the top of the window
	always_comb
	begin
		lead = lead_one(s2.mag);
		s3_d = s2;
		s3_d.mag = s2.mag << (LZW'(SUMW - 1) - lead);
		s3_d.exp = s2.exp + $signed({{(XW-LZW){1'b0}}, lead}) - XW'(UNIT);
	end

	// Round to nearest even and classify
	always_comb
	begin
		up = s3.mag[SUMW-SW-2] & (s3.mag[SUMW-SW-1] | (|s3.mag[SUMW-SW-3:0]));
		rnd = {1'b0, s3.mag[SUMW-1 -: SW+1]} + {{(SW+1){1'b0}}, up};
		r_exp = s3.exp + $signed({{(XW-1){1'b0}}, rnd[SW+1]});	// Carry out
		ovf = !r_exp[XW-1] && (r_exp >= EMAX);
		unf = r_exp[XW-1] || (r_exp == '0);			// Flush to +0
		res_d.valid = s3.valid;
		res_d.nan = s3.nan;
		res_d.inf = !s3.nan && (s3.inf || (!s3.zero && ovf));
		res_d.zero = !s3.nan && !res_d.inf && (s3.zero || unf);
		if (res_d.nan || res_d.zero)
			res_d.sign = 1'b0;
		else if (s3.inf)
			res_d.sign = s3.inf_sign;
		else
			res_d.sign = s3.sign;				// Finite or overflow
		res_d.exp = r_exp[EW-1:0];
		res_d.sig = rnd[SW+1] ? rnd[SW+1:1] : rnd[SW:0];
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			s1.valid <= 1'b0;
			s2.valid <= 1'b0;
			s3.valid <= 1'b0;
			o_res.valid <= 1'b0;
		end
		else
		begin
			s1.valid <= i_op.valid;
			s2.valid <= s1.valid;
			s3.valid <= s2.valid;
			o_res.valid <= s3.valid;
			if (i_op.valid)
				s1 <= s1_d;		// Stage 1, product
			if (s1.valid)
				s2 <= s2_d;		// Stage 2, sum
			if (s2.valid)
				s3 <= s3_d;		// Stage 3, normalized
			if (s3.valid)
				o_res <= res_d;		// Stage 4, rounded
		end
	end

	// Pipeline valids never go unknown after reset
	a_valid_known: assert property (@(posedge clk) disable iff (!nrst)
		!$isunknown({s1.valid, s2.valid, s3.valid, o_res.valid}));

	// NaN and inf are exclusive in a result
	a_nan_inf: assert property (@(posedge clk) disable iff (!nrst)
		o_res.valid |-> !(o_res.nan && o_res.inf));

endmodule

// File: verilog/vmac_collect.sv
`timescale 1ns/1ps

// Vector MAC result collection
// Packs lane results into float words, forms the summary flags
// and registers both

module vmac_collect (
	input  logic						clk,
	input  logic						nrst,
	input  vmac_pkg::lane_res_t [vmac_pkg::N_LANES-1:0]	i_lane,
	output flp_pkg::flp_word_t [vmac_pkg::N_LANES-1:0]	o_res,
	output vmac_pkg::vmac_status_t				o_status
);

	flp_pkg::flp_word_t [vmac_pkg::N_LANES-1:0]	res_d;
	vmac_pkg::vmac_status_t				status_d;
	logic [vmac_pkg::N_LANES-1:0]			valids;

	function automatic flp_pkg::flp_word_t pack(input vmac_pkg::lane_res_t r);
		flp_pkg::flp_word_t	w;
		w.bits = '0;					// +0 by default
		if (r.nan)
			w.bits = flp_pkg::QNAN;
		else if (r.inf)
		begin
			w.f.sign = r.sign;
			w.f.exp = '1;				// Zero fraction
		end
		else if (!r.zero)
		begin
			w.f.sign = r.sign;
			w.f.exp = r.exp;
			w.f.frac = r.sig[flp_pkg::SWIDTH-1:0];	// Hidden bit dropped
		end
		return w;
	endfunction

	always_comb
	begin
		status_d.any_nan = 1'b0;
		status_d.any_inf = 1'b0;
		status_d.all_zero = 1'b1;
		for (int k = 0; k < vmac_pkg::N_LANES; k++)
		begin
			res_d[k] = pack(i_lane[k]);
			valids[k] = i_lane[k].valid;
			status_d.any_nan |= i_lane[k].nan;
			status_d.any_inf |= i_lane[k].inf;
			status_d.all_zero &= i_lane[k].zero;
		end
		status_d.valid = valids[0];	// Lanes run in step
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			o_status.valid <= 1'b0;
		else
		begin
			o_status.valid <= status_d.valid;
			if (status_d.valid)
			begin
				o_status <= status_d;
				o_res <= res_d;
			end
		end
	end

	// All lanes deliver in the same cycle
	a_lanes_in_step: assert property (@(posedge clk) disable iff (!nrst)
		(&valids) || !(|valids));

endmodule

// File: verilog/vmac_top.sv
`timescale 1ns/1ps

// Vector floating point multiply-accumulate, a + b*c per lane
// Dispatch, one MAC lane per element, collection; 6 cycle latency

module vmac_top (
	input  logic						clk,
	input  logic						nrst,
	input  vmac_pkg::vmac_req_t				i_req,		// Request strobe
	output flp_pkg::flp_word_t [vmac_pkg::N_LANES-1:0]	o_res,		// Lane results
	output vmac_pkg::vmac_status_t				o_status	// Summary
);

	vmac_pkg::lane_in_t [vmac_pkg::N_LANES-1:0]	lane_in;	// Unpacked operands
	vmac_pkg::lane_res_t [vmac_pkg::N_LANES-1:0]	lane_res;	// Before packing

	vmac_dispatch disp0 (
		.clk(clk),
		.nrst(nrst),
		.i_req(i_req),
		.o_lane(lane_in)
	);

	for (genvar k = 0; k < vmac_pkg::N_LANES; k++)
	begin : g_lane
		flp_mac_lane lane (
			.clk(clk),
			.nrst(nrst),
			.i_op(lane_in[k]),
			.o_res(lane_res[k])
		);
	end

	vmac_collect coll0 (
		.clk(clk),
		.nrst(nrst),
		.i_lane(lane_res),
		.o_res(o_res),
		.o_status(o_status)
	);

endmodule

// File: verification/tb_clkgen.sv
`timescale 1ns/1ps

// Testbench clock and reset source
// 20 ns clock, nrst held low for the first 16 rising edges

module tb_clkgen (
	output logic	o_clk,
	output logic	o_nrst
);

	initial
	begin
		o_clk = 1'b0;
		o_nrst = 1'b0;				// Reset from time zero
		repeat (16) @(posedge o_clk);
		o_nrst <= 1'b1;
	end

	always #10 o_clk = ~o_clk;			// Half of the 20 ns period

endmodule

// File: verification/tb_vmac.sv
`timescale 1ns/1ps

// Testbench for the vector MAC unit
// Drives requests, predicts every lane from the arithmetic rules
// and checks results, summary flags and the 6 cycle latency

module tb_vmac;

	localparam int NL = vmac_pkg::N_LANES;
	localparam int LATENCY = 6;	// Request visible to result visible
	localparam int TIMEOUT = 200;	// Cycles per wait loop

	logic				clk;
	logic				nrst;
	vmac_pkg::vmac_req_t		i_req;
	flp_pkg::flp_word_t [NL-1:0]	o_res;
	vmac_pkg::vmac_status_t		o_status;

	vmac_pkg::vmac_req_t	req_q[$];	// Requests in flight
	int			issue_q[$];	// Cycle each one became visible
	int			cyc = 0;
	int			checks = 0;
	int			errors = 0;
	int			outputs = 0;	// Results seen, reset included
	logic [31:0]		lfsr;
	logic [NL-1:0][31:0]	last_res;	// Latest output words
	vmac_pkg::vmac_status_t	last_status;

	tb_clkgen clkgen0 (
		.o_clk(clk),
		.o_nrst(nrst)
	);

	vmac_top dut0 (
		.clk(clk),
		.nrst(nrst),
		.i_req(i_req),
		.o_res(o_res),
		.o_status(o_status)
	);

	always @(posedge clk)
		cyc <= cyc + 1;

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);	// x^32+x^22+x^2+x+1
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = galois_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic rand_normal(output logic [31:0] w);
		logic [31:0]	s;
		logic [31:0]	e;
		logic [31:0]	f;
		take_bits(1, s);
		take_bits(6, e);
		take_bits(23, f);
		w = {s[0], 8'd96 + e[7:0], f[22:0]};	// Exponent 96..159, no overflow
	endtask

	// Expected a + b*c of one lane
	function automatic logic [31:0] ref_lane(input logic [31:0] a, b, c);
		logic [71:0]	wa;		// Unit bit at 69 for both terms
		logic [71:0]	wp;
		logic [71:0]	sum;
		logic [47:0]	prod;
		logic [24:0]	rounded;
		logic		sp;
		logic		sr;
		int		ea;
		int		eb;
		int		ec;
		int		ep;
		int		er;
		int		msb;
		ea = int'(a[30:23]);
		eb = int'(b[30:23]);
		ec = int'(c[30:23]);
		sp = b[31] ^ c[31];
		if ((ea == 255 && a[22:0] != 0) || (eb == 255 && b[22:0] != 0)
			|| (ec == 255 && c[22:0] != 0))
			return flp_pkg::QNAN;				// NaN operand
		if ((eb == 0 && ec == 255) || (eb == 255 && ec == 0))
			return flp_pkg::QNAN;				// Zero times inf
		if (ea == 255 && (eb == 255 || ec == 255) && a[31] != sp)
			return flp_pkg::QNAN;				// inf - inf
		if (ea == 255)
			return {a[31], 8'hFF, 23'd0};
		if (eb == 255 || ec == 255)
			return {sp, 8'hFF, 23'd0};
		prod = {24'd0, 1'b1, b[22:0]} * {24'd0, 1'b1, c[22:0]};	// Exact
		ep = eb + ec - 127;
		wa = (ea == 0) ? '0 : {2'b0, 1'b1, a[22:0], 46'd0};	// Denormal as zero
		wp = (eb == 0 || ec == 0) ? '0 : {1'b0, prod, 23'd0};
		if (wa == '0)
			er = ep;
		else if (wp == '0)
			er = ea;
		else if (ea >= ep)
		begin
			wp = wp >> (ea - ep);				// Truncated, no sticky
			er = ea;
		end
		else
		begin
			wa = wa >> (ep - ea);
			er = ep;
		end
		sr = a[31];
		if (a[31] == sp)
			sum = wa + wp;
		else if (wa >= wp)
			sum = wa - wp;
		else
		begin
			sum = wp - wa;
			sr = sp;
		end
		if (sum == '0)
			return 32'h0;					// Cancelled, +0
		msb = 71;
		while (!sum[msb])
			msb--;
		sum = sum << (71 - msb);
		er = er + msb - 69;
		rounded = {1'b0, sum[71:48]};
		if (sum[47] && (sum[48] || (|sum[46:0])))
			rounded = rounded + 25'd1;			// Nearest even
		if (rounded[24])
		begin
			rounded = rounded >> 1;
			er++;
		end
		if (er >= 255)
			return {sr, 8'hFF, 23'd0};
		if (er <= 0)
			return 32'h0;					// Flush to +0
		return {sr, er[7:0], rounded[22:0]};
	endfunction

	function automatic vmac_pkg::vmac_status_t ref_status(input logic [NL-1:0][31:0] w);
		vmac_pkg::vmac_status_t	st;
		st = {1'b0, 1'b0, 1'b1, 1'b1};		// any_nan, any_inf, all_zero, valid
		for (int k = 0; k < NL; k++)
		begin
			st.any_nan |= (w[k] == flp_pkg::QNAN);
			st.any_inf |= (w[k][30:0] == 31'h7F80_0000);
			st.all_zero &= (w[k] == 32'h0);
		end
		return st;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		assert (got === want)
		else
		begin
			errors++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, want);
		end
	endtask

	// Literal lane results, lane k gets want[k % 4]
	task automatic check_lanes(input logic [3:0][31:0] want);
		for (int k = 0; k < NL; k++)
			check_value($sformatf("o_res[%0d]", k), last_res[k], want[k % 4]);
	endtask

	task automatic check_flags(input logic want_nan, input logic want_inf,
		input logic want_zero);
		check_value("o_status", 32'(last_status),
			32'({want_nan, want_inf, want_zero, 1'b1}));
	endtask

	function automatic vmac_pkg::vmac_req_t build_req(input logic [31:0] b,
		input logic [3:0][31:0] a, input logic [3:0][31:0] c);
		vmac_pkg::vmac_req_t	r;
		r.valid = 1'b1;
		r.b.bits = b;
		for (int k = 0; k < NL; k++)
		begin
			r.a[k].bits = a[k % 4];
			r.c[k].bits = c[k % 4];
		end
		return r;
	endfunction

	task automatic drive_req(input vmac_pkg::vmac_req_t r);
		@(posedge clk);
		i_req <= r;
		req_q.push_back(r);
		issue_q.push_back(cyc + 1);	// Visible in the next cycle
	endtask

	task automatic drive_idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			i_req.valid <= 1'b0;
		end
	endtask

	task automatic end_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("sim failed");
		$finish;
	endtask

	task automatic wait_reset_release();
		int	n;
		n = 0;
		while (nrst !== 1'b1 && n < TIMEOUT)
		begin
			@(posedge clk);
			n++;
		end
		if (nrst !== 1'b1)
			end_on_timeout("reset release");
	endtask

	task automatic wait_drain();
		int	n;
		n = 0;
		while (req_q.size() != 0 && n < TIMEOUT)
		begin
			@(posedge clk);
			n++;
		end
		if (req_q.size() != 0)
			end_on_timeout("results of the requests in flight");
	endtask

	task automatic report_test(input string name, input int c0, input int e0);
		$display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
	endtask

	// Outputs sampled mid-cycle, away from the rising edge
	always @(negedge clk)
	begin : compare
		vmac_pkg::vmac_req_t	r;
		logic [NL-1:0][31:0]	want;
		int			issued;
		if (o_status.valid !== 1'b0)
		begin
			outputs++;
			checks++;
			assert (req_q.size() != 0)
			else
			begin
				errors++;
				$display("Output valid at %0t with no request in flight", $time);
			end
			if (req_q.size() != 0)
			begin
				r = req_q.pop_front();
				issued = issue_q.pop_front();
				check_value("latency", cyc - issued, LATENCY);
				for (int k = 0; k < NL; k++)
				begin
					want[k] = ref_lane(r.a[k].bits, r.b.bits, r.c[k].bits);
					check_value($sformatf("o_res[%0d]", k), o_res[k].bits, want[k]);
					last_res[k] = o_res[k].bits;
				end
				check_value("o_status", 32'(o_status), 32'(ref_status(want)));
				last_status = o_status;
			end
		end
	end

	initial
	begin : stimulus
		int			c0;
		int			e0;
		int			sent;
		logic [31:0]		burst;
		logic [31:0]		gap;
		logic [31:0]		w;
		vmac_pkg::vmac_req_t	r;
		i_req = '0;
		lfsr = 32'd7187;

		c0 = checks;
		e0 = errors;
		wait_reset_release();
		repeat (10) @(posedge clk);			// Idle after reset
		check_value("results while idle", outputs, 0);
		drive_req(build_req(32'h3F80_0000, {4{32'h3F80_0000}}, {4{32'h4000_0000}}));
		drive_idle(1);
		wait_drain();
		check_value("results after one request", outputs, 1);
		report_test("reset and latency", c0, e0);

		c0 = checks;
		e0 = errors;
		// b = 3, lanes 3..0: -1+3*1, 0.5+3*2, 1+3*1, 2+3*4
		drive_req(build_req(32'h4040_0000,
			{32'hBF80_0000, 32'h3F00_0000, 32'h3F80_0000, 32'h4000_0000},
			{32'h3F80_0000, 32'h4000_0000, 32'h3F80_0000, 32'h4080_0000}));
		drive_idle(1);
		wait_drain();
		check_lanes({32'h4000_0000, 32'h40D0_0000, 32'h4080_0000, 32'h4160_0000});
		drive_req(build_req(32'hBF80_0000, {4{32'h3F80_0000}}, {4{32'h3F80_0000}}));
		drive_idle(1);
		wait_drain();
		check_lanes({4{32'h0}});			// 1 + (-1)*1 everywhere
		check_flags(1'b0, 1'b0, 1'b1);
		report_test("small integers", c0, e0);

		c0 = checks;
		e0 = errors;
		sent = 0;
		while (sent < 500)
		begin
			take_bits(3, burst);
			for (int i = 0; i <= int'(burst) && sent < 500; i++)
			begin
				r.valid = 1'b1;
				rand_normal(w);
				r.b.bits = w;
				for (int k = 0; k < NL; k++)
				begin
					rand_normal(w);
					r.a[k].bits = w;
					rand_normal(w);
					r.c[k].bits = w;
				end
				drive_req(r);
				sent++;
			end
			take_bits(2, gap);
			drive_idle(int'(gap));			// Gap of 0 to 3 cycles
		end
		drive_idle(1);
		wait_drain();
		report_test("random normals", c0, e0);

		c0 = checks;
		e0 = errors;
		// b = +inf: -inf + -1*inf, inf + -1*inf, 1 + 2*inf, 1 + 0*inf
		drive_req(build_req(32'h7F80_0000,
			{32'hFF80_0000, 32'h7F80_0000, 32'h3F80_0000, 32'h3F80_0000},
			{32'hBF80_0000, 32'hBF80_0000, 32'h4000_0000, 32'h0000_0000}));
		drive_idle(1);
		wait_drain();
		check_lanes({32'hFF80_0000, flp_pkg::QNAN, 32'h7F80_0000, flp_pkg::QNAN});
		check_flags(1'b1, 1'b1, 1'b0);
		// b = 2: denormal a, -inf a, denormal c, NaN a
		drive_req(build_req(32'h4000_0000,
			{32'h0000_0010, 32'hFF80_0000, 32'h4040_0000, 32'h7FA0_0000},
			{32'h3F00_0000, 32'h3F80_0000, 32'h0000_0001, 32'h3F80_0000}));
		drive_idle(1);
		wait_drain();
		check_lanes({32'h3F80_0000, 32'hFF80_0000, 32'h4040_0000, flp_pkg::QNAN});
		check_flags(1'b1, 1'b1, 1'b0);
		report_test("special operands", c0, e0);

		c0 = checks;
		e0 = errors;
		// b = 2^127: 1.5*b, 1*b, 1 - 2*b, 4*b
		drive_req(build_req(32'h7F00_0000,
			{32'h0000_0000, 32'h0000_0000, 32'h3F80_0000, 32'h0000_0000},
			{32'h3FC0_0000, 32'h3F80_0000, 32'hC000_0000, 32'h4080_0000}));
		drive_idle(1);
		wait_drain();
		check_lanes({32'h7F40_0000, 32'h7F00_0000, 32'hFF80_0000, 32'h7F80_0000});
		check_flags(1'b0, 1'b1, 1'b0);
		// b = 2^-100: times 2^-27, 2^-26, -2^-100, 2^-100
		drive_req(build_req(32'h0D80_0000, {4{32'h0000_0000}},
			{32'h3200_0000, 32'h3280_0000, 32'h8D80_0000, 32'h0D80_0000}));
		drive_idle(1);
		wait_drain();
		check_lanes({32'h0000_0000, 32'h0080_0000, 32'h0000_0000, 32'h0000_0000});
		check_flags(1'b0, 1'b0, 1'b0);
		report_test("overflow and underflow", c0, e0);

		$display("checks %0d, errors %0d, results %0d", checks, errors, outputs);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: list.f
verilog/flp_pkg.sv
verilog/vmac_pkg.sv
verilog/vmac_dispatch.sv
verilog/flp_mac_lane.sv
verilog/vmac_collect.sv
verilog/vmac_top.sv
verification/tb_clkgen.sv
verification/tb_vmac.sv

// File: Makefile
# Verilator build and run of the vector MAC testbench
# Any variable below can be set on the command line, e.g. make sim BUILD=out

VERILATOR ?= verilator
TOP       ?= tb_vmac
FLIST     ?= list.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
JOBS      ?= 0

SOURCES := $(shell cat $(FLIST))
BIN     := $(BUILD)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --assert $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary --assert $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(BUILD) -j $(JOBS)

sim: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
